//--- bench/mmio_bus_models.sv
`default_nettype none

// data cache responder, 64-bit words with byte lanes.
module cache_model
    import mmio_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  core_req_t req,
    output core_rsp_t rsp
);

    logic [63:0] mem [logic [63:0]];
    int unsigned wait_left;
    bit          counting;

    function automatic logic [63:0] fetch(input logic [63:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 64'h5a5a_c3c3_0ff0_9669;
    endfunction

    initial begin
        core_rsp_t   next_rsp;
        logic [63:0] word;
        int          i;
        rsp       = '0;
        counting  = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            next_rsp = '0;
            if (rsp.finish) begin
                // request drops after this edge.
                counting = 1'b0;
            end else if (!rst && (req.we || req.re)) begin
                if (!counting) begin
                    counting  = 1'b1;
                    wait_left = $urandom_range(0, 3);
                end
                if (wait_left == 0) begin
                    word = fetch(req.addr);
                    if (req.we) begin
                        for (i = 0; i < 8; i++) begin
                            if (req.mask[i]) begin
                                word[i*8 +: 8] = req.data[i*8 +: 8];
                            end
                        end
                        mem[req.addr] = word;
                    end else begin
                        next_rsp.data = word;
                    end
                    next_rsp.finish = 1'b1;
                    counting        = 1'b0;
                end else begin
                    wait_left--;
                end
            end
            #2;
            rsp = next_rsp;
        end
    end

endmodule

// device bus responder, 32-bit words, logs every beat.
module bus_model
    import mmio_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  arb_req_t req,
    output arb_rsp_t rsp
);

    logic [31:0] mem [logic [63:0]];
    arb_req_t    beats[$];
    int unsigned wait_left;
    bit          counting;

    function automatic logic [31:0] fetch(input logic [63:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr[63:32] ^ addr[31:0] ^ 32'h3c3c_a5a5;
    endfunction

    function automatic int beat_count();
        return beats.size();
    endfunction

    function automatic void pop_beat(output arb_req_t b);
        b = beats.pop_front();
    endfunction

    function automatic void clear_beats();
        beats.delete();
    endfunction

    initial begin
        arb_rsp_t    next_rsp;
        logic [31:0] word;
        int          i;
        rsp       = '0;
        counting  = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            next_rsp = '0;
            if (rsp.finish) begin
                counting = 1'b0;
            end else if (!rst && (req.we || req.re)) begin
                if (!counting) begin
                    counting  = 1'b1;
                    wait_left = $urandom_range(0, 5);
                end
                if (wait_left == 0) begin
                    beats.push_back(req);
                    word = fetch(req.addr);
                    if (req.we) begin
                        for (i = 0; i < 4; i++) begin
                            if (req.mask[i]) begin
                                word[i*8 +: 8] = req.data[i*8 +: 8];
                            end
                        end
                        mem[req.addr] = word;
                    end else begin
                        next_rsp.data = word;
                    end
                    next_rsp.finish = 1'b1;
                    counting        = 1'b0;
                end else begin
                    wait_left--;
                end
            end
            #2;
            rsp = next_rsp;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_mmio_subsystem.sv
`default_nettype none

`include "mmio_consts.svh"

module tb_mmio_subsystem
    import mmio_pkg::*;
();

    logic          clk;
    logic          rst;
    core_req_t     core_req;
    core_rsp_t     core_rsp;
    access_class_t mmio_sign;
    core_req_t     dcache_req;
    core_rsp_t     dcache_rsp;
    arb_req_t      arb_req;
    arb_rsp_t      arb_rsp;

    logic [63:0] ref_cached [logic [63:0]];
    logic [31:0] ref_dev [logic [63:0]];
    int          errors;
    int          timeouts;
    int          accesses;
    bit          timed_out;

    mmio_subsystem_top mmio_subsystem_top_inst (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_rsp   (core_rsp),
        .mmio_sign  (mmio_sign),
        .dcache_req (dcache_req),
        .dcache_rsp (dcache_rsp),
        .arb_req    (arb_req),
        .arb_rsp    (arb_rsp)
    );

    cache_model cache_model_inst (
        .clk (clk),
        .rst (rst),
        .req (dcache_req),
        .rsp (dcache_rsp)
    );

    bus_model bus_model_inst (
        .clk (clk),
        .rst (rst),
        .req (arb_req),
        .rsp (arb_rsp)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [63:0] expect_cached(input logic [63:0] addr);
        if (ref_cached.exists(addr)) begin
            return ref_cached[addr];
        end
        return addr ^ 64'h5a5a_c3c3_0ff0_9669;
    endfunction

    function automatic logic [31:0] expect_dev(input logic [63:0] addr);
        if (ref_dev.exists(addr)) begin
            return ref_dev[addr];
        end
        return addr[63:32] ^ addr[31:0] ^ 32'h3c3c_a5a5;
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0] mask);
        logic [63:0] r;
        int          i;
        r = old_word;
        for (i = 0; i < 8; i++) begin
            if (mask[i]) begin
                r[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic check_reset_outputs();
        if (arb_req.we !== 1'b0 || arb_req.re !== 1'b0 || core_rsp.finish !== 1'b0) begin
            report_error("bus strobes or core finish high around reset");
        end
    endtask

    // per-cycle checks on class code, fence and path isolation.
    task automatic check_cycle(input bit dev, input bit clint, input bit fence,
                               input bit active);
        logic [2:0] want_sign;
        want_sign = (active && clint) ? 3'b010 : 3'b100;
        if (mmio_sign !== want_sign) begin
            report_error($sformatf("mmio_sign %b, expected %b", mmio_sign, want_sign));
        end
        if (dcache_req.fence !== fence) begin
            report_error("dcache fence differs from core fence");
        end
        if (active && dev && (dcache_req.we !== 1'b0 || dcache_req.re !== 1'b0)) begin
            report_error("dcache strobe high during uncached access");
        end
        if (active && !dev && (arb_req.we !== 1'b0 || arb_req.re !== 1'b0)) begin
            report_error("bus strobe high during cached access");
        end
    endtask

    task automatic check_beat(input arb_req_t b, input logic [63:0] addr, input bit write,
                              input logic [31:0] data, input logic [3:0] mask);
        if (b.addr !== addr) begin
            report_error($sformatf("beat addr %h, expected %h", b.addr, addr));
        end
        if (b.we !== write || b.re !== !write) begin
            report_error($sformatf("beat at %h has wrong direction", addr));
        end
        if (write && b.data !== data) begin
            report_error($sformatf("beat data %h, expected %h", b.data, data));
        end
        if (b.mask !== mask) begin
            report_error($sformatf("beat mask %b, expected %b", b.mask, mask));
        end
    endtask

    // picks a slot in the cached area or in one of the four device regions.
    task automatic pick_target(output logic [63:0] addr, output bit dev, output bit clint);
        int unsigned roll;
        int unsigned slot;
        logic [63:0] off;
        roll  = $urandom_range(0, 99);
        slot  = $urandom_range(0, 7);
        off   = {58'd0, slot[2:0], 3'b000};
        dev   = 1'b1;
        clint = 1'b0;
        if (roll < 60) begin
            dev  = 1'b0;
            addr = 64'h0000_0000_8000_0000 + off;
        end else if (roll < 70) begin
            addr = `MMIO_UART_START + off;
        end else if (roll < 80) begin
            addr = `MMIO_SPICTRL_START + off;
        end else if (roll < 90) begin
            addr = `MMIO_SPI_START + off;
        end else begin
            addr  = `MMIO_CLINT_START + off;
            clint = 1'b1;
        end
    endtask

    // called 2 units after a rising edge; returns at the same offset.
    task automatic run_access(input logic [63:0] addr, input bit dev, input bit clint,
                              input bit write, input logic [63:0] data,
                              input logic [7:0] mask, input bit fence);
        int          cycles;
        bit          done;
        logic [63:0] got;
        logic [63:0] want;
        logic [63:0] up_addr;
        logic [63:0] lo_addr;
        arb_req_t    up_beat;
        arb_req_t    lo_beat;
        core_req.addr  = addr;
        core_req.data  = data;
        core_req.mask  = mask;
        core_req.we    = write;
        core_req.re    = !write;
        core_req.fence = fence;
        cycles = 0;
        done   = 1'b0;
        got    = '0;
        while (!done && cycles < 200) begin
            @(posedge clk);
            cycles++;
            check_cycle(dev, clint, fence, 1'b1);
            if (core_rsp.finish === 1'b1) begin
                done = 1'b1;
                got  = core_rsp.data;
            end
        end
        #2;
        core_req.we = 1'b0;
        core_req.re = 1'b0;
        accesses++;
        if (!done) begin
            timeouts++;
            timed_out = 1'b1;
            $display("Timeout: access to %h got no finish within 200 cycles", addr);
            return;
        end
        up_addr = {addr[63:3], 3'b100};
        lo_addr = {addr[63:3], 3'b000};
        if (!dev) begin
            if (bus_model_inst.beat_count() != 0) begin
                report_error($sformatf("bus beats seen for cached access to %h", addr));
                bus_model_inst.clear_beats();
            end
            if (write) begin
                ref_cached[addr] = merge_bytes(expect_cached(addr), data, mask);
            end else if (got !== expect_cached(addr)) begin
                report_error($sformatf("cached read %h: got %h, expected %h",
                                       addr, got, expect_cached(addr)));
            end
        end else if (bus_model_inst.beat_count() != 2) begin
            report_error($sformatf("%0d beats for uncached access to %h",
                                   bus_model_inst.beat_count(), addr));
            bus_model_inst.clear_beats();
        end else begin
            bus_model_inst.pop_beat(up_beat);
            bus_model_inst.pop_beat(lo_beat);
            check_beat(up_beat, up_addr, write, data[63:32], mask[7:4]);
            check_beat(lo_beat, lo_addr, write, data[31:0], mask[3:0]);
            want = {expect_dev(up_addr), expect_dev(lo_addr)};
            if (write) begin
                want              = merge_bytes(want, data, mask);
                ref_dev[up_addr]  = want[63:32];
                ref_dev[lo_addr]  = want[31:0];
            end else if (got !== want) begin
                report_error($sformatf("uncached read %h: got %h, expected %h",
                                       addr, got, want));
            end
        end
    endtask

    initial begin
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [31:0] r_ctl;
        logic [63:0] addr;
        bit          dev;
        bit          clint;
        int unsigned idle;
        int unsigned k;
        int          n;
        // seed the generator once.
        r_ctl     = $urandom(32'ha249_5888);
        errors    = 0;
        timeouts  = 0;
        accesses  = 0;
        timed_out = 1'b0;
        rst       = 1'b1;
        core_req  = '0;
        // device address, so the core finish comes from the splitter.
        core_req.addr = `MMIO_UART_START;
        dev       = 1'b0;
        clint     = 1'b0;
        @(posedge clk);
        for (n = 1; n < 10; n++) begin
            @(posedge clk);
            check_reset_outputs();
        end
        #2;
        rst = 1'b0;
        repeat (2) begin
            @(posedge clk);
            check_reset_outputs();
        end
        #2;
        for (n = 0; n < 300 && !timed_out; n++) begin
            pick_target(addr, dev, clint);
            r_hi  = $urandom();
            r_lo  = $urandom();
            r_ctl = $urandom();
            run_access(addr, dev, clint, r_ctl[0], {r_hi, r_lo}, r_ctl[15:8], r_ctl[1]);
            idle = $urandom_range(0, 2);
            for (k = 0; k < idle && !timed_out; k++) begin
                @(posedge clk);
                check_cycle(dev, clint, r_ctl[1], 1'b0);
                #2;
            end
        end
        $display("accesses: %0d, value errors: %0d, timeouts: %0d",
                 accesses, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f \
    --top-module tb_mmio_subsystem \
    --Mdir obj_dir -o tb_mmio_subsystem

./obj_dir/tb_mmio_subsystem > sim.log 2>&1
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed, see sim.log"
    exit 1
fi

//--- src.f
+incdir+verilog
verilog/mmio_pkg.sv
verilog/mmio_region_decode.sv
verilog/uncache_splitter.sv
verilog/mem_access_router.sv
verilog/mmio_subsystem_top.sv
bench/mmio_bus_models.sv
bench/tb_mmio_subsystem.sv

//--- verilog/mem_access_router.sv
`default_nettype none

module mem_access_router
    import mmio_pkg::*;
(
    input  core_req_t core_req,
    input  logic      uncached,
    output core_rsp_t core_rsp,
    output core_req_t dcache_req,
    input  core_rsp_t dcache_rsp,
    output logic      split_start,
    input  core_rsp_t split_rsp
);

    logic req_active;

    assign req_active = core_req.we | core_req.re;

    // cache side, blanked for device accesses.
    always_comb begin
        if (uncached) begin
            dcache_req = '0;
        end else begin
            dcache_req = core_req;
        end
        // fence goes to the cache no matter where the access points.
        dcache_req.fence = core_req.fence;
    end

    // splitter only kicks off for a live device access.
    assign split_start = uncached & req_active;

    // response comes back from whichever side owns the address.
    always_comb begin
        if (uncached) begin
            core_rsp = split_rsp;
        end else begin
            core_rsp = dcache_rsp;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mmio_consts.svh
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// widths of the core port and the device bus.
`define MMIO_ADDR_W 64
`define MMIO_DATA_W 64
`define MMIO_BEAT_W 32

// uart registers.
`define MMIO_UART_START 64'h0000_0000_1000_0000
`define MMIO_UART_END 64'h0000_0000_1000_0fff

// spi controller registers.
`define MMIO_SPICTRL_START 64'h0000_0000_1000_1000
`define MMIO_SPICTRL_END 64'h0000_0000_1000_1fff

// spi flash, memory mapped read window.
`define MMIO_SPI_START 64'h0000_0000_3000_0000
`define MMIO_SPI_END 64'h0000_0000_3fff_ffff

// clint, timer compare and software interrupt.
`define MMIO_CLINT_START 64'h0000_0000_0200_0000
`define MMIO_CLINT_END 64'h0000_0000_0200_ffff

`endif

//--- verilog/mmio_pkg.sv
`default_nettype none

`include "mmio_consts.svh"

package mmio_pkg;

    // core side request, also what the data cache sees.
    typedef struct packed {
        logic [`MMIO_ADDR_W-1:0]   addr;
        logic [`MMIO_DATA_W-1:0]   data;
        logic [`MMIO_DATA_W/8-1:0] mask;
        logic                      we;
        logic                      re;
        logic                      fence;
    } core_req_t;

    typedef struct packed {
        logic [`MMIO_DATA_W-1:0] data;
        logic                    finish;
    } core_rsp_t;

    // one 32-bit beat towards the bus arbiter.
    typedef struct packed {
        logic [`MMIO_ADDR_W-1:0]   addr;
        logic [`MMIO_BEAT_W-1:0]   data;
        logic [`MMIO_BEAT_W/8-1:0] mask;
        logic                      we;
        logic                      re;
    } arb_req_t;

    typedef struct packed {
        logic [`MMIO_BEAT_W-1:0] data;
        logic                    finish;
    } arb_rsp_t;

    // same 64 bits, seen whole or as two bus halves.
    typedef union packed {
        logic [`MMIO_DATA_W-1:0] word;
        struct packed {
            logic [`MMIO_BEAT_W-1:0] hi;
            logic [`MMIO_BEAT_W-1:0] lo;
        } half;
    } split_word_u;

    typedef enum logic [2:0] {
        ACC_CLINT = 3'b010,
        ACC_OTHER = 3'b100
    } access_class_t;

endpackage

`default_nettype wire

//--- verilog/mmio_region_decode.sv
`default_nettype none

`include "mmio_consts.svh"

module mmio_region_decode
    import mmio_pkg::*;
(
    input  logic [63:0]   addr,
    input  logic          req_active,
    output logic          uncached,
    output access_class_t access_class
);

    logic in_uart;
    logic in_spictrl;
    logic in_spi;
    logic in_clint;

    // bounds are inclusive on both ends.
    function automatic logic in_range(
        input logic [63:0] a,
        input logic [63:0] lo,
        input logic [63:0] hi
    );
        return (a >= lo) && (a <= hi);
    endfunction

    assign in_uart    = in_range(addr, `MMIO_UART_START, `MMIO_UART_END);
    assign in_spictrl = in_range(addr, `MMIO_SPICTRL_START, `MMIO_SPICTRL_END);
    assign in_spi     = in_range(addr, `MMIO_SPI_START, `MMIO_SPI_END);
    assign in_clint   = in_range(addr, `MMIO_CLINT_START, `MMIO_CLINT_END);

    // everything outside the device regions goes through the cache.
    assign uncached = in_uart | in_spictrl | in_spi | in_clint;

    // clint class only while a load or store is actually presented.
    always_comb begin
        if (req_active && in_clint) begin
            access_class = ACC_CLINT;
        end else begin
            access_class = ACC_OTHER;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mmio_subsystem_top.sv
`default_nettype none

module mmio_subsystem_top
    import mmio_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  core_req_t     core_req,
    output core_rsp_t     core_rsp,
    output access_class_t mmio_sign,
    output core_req_t     dcache_req,
    input  core_rsp_t     dcache_rsp,
    output arb_req_t      arb_req,
    input  arb_rsp_t      arb_rsp
);

    logic      uncached;
    logic      split_start;
    core_rsp_t split_rsp;

    mmio_region_decode decode_inst (
        .addr         (core_req.addr),
        .req_active   (core_req.we | core_req.re),
        .uncached     (uncached),
        .access_class (mmio_sign)
    );

    mem_access_router router_inst (
        .core_req    (core_req),
        .uncached    (uncached),
        .core_rsp    (core_rsp),
        .dcache_req  (dcache_req),
        .dcache_rsp  (dcache_rsp),
        .split_start (split_start),
        .split_rsp   (split_rsp)
    );

    // device accesses become two 32-bit beats.
    uncache_splitter splitter_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (split_start),
        .req     (core_req),
        .arb_req (arb_req),
        .arb_rsp (arb_rsp),
        .rsp     (split_rsp)
    );

endmodule

`default_nettype wire

//--- verilog/uncache_splitter.sv
`default_nettype none

module uncache_splitter
    import mmio_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  core_req_t req,
    output arb_req_t  arb_req,
    input  arb_rsp_t  arb_rsp,
    output core_rsp_t rsp
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_UPPER = 2'd1;
    localparam logic [1:0] ST_LOWER = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic [1:0]  state;
    logic [1:0]  state_next;
    core_req_t   req_q;
    split_word_u wr_word;
    split_word_u rd_word;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_UPPER;
                end
            end
            ST_UPPER: begin
                if (arb_rsp.finish) begin
                    state_next = ST_LOWER;
                end
            end
            ST_LOWER: begin
                if (arb_rsp.finish) begin
                    state_next = ST_DONE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // hold the access so both beats see the same fields.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            req_q <= req;
        end
    end

    // upper half lands first, lower half second.
    always_ff @(posedge clk) begin
        if (arb_rsp.finish) begin
            if (state == ST_UPPER) begin
                rd_word.half.hi <= arb_rsp.data;
            end else if (state == ST_LOWER) begin
                rd_word.half.lo <= arb_rsp.data;
            end
        end
    end

    assign wr_word.word = req_q.data;

    always_comb begin
        arb_req = '0;
        case (state)
            ST_UPPER: begin
                arb_req.addr = {req_q.addr[63:3], 3'b100};
                arb_req.data = wr_word.half.hi;
                arb_req.mask = req_q.mask[7:4];
                arb_req.we   = req_q.we;
                arb_req.re   = req_q.re;
            end
            ST_LOWER: begin
                arb_req.addr = {req_q.addr[63:3], 3'b000};
                arb_req.data = wr_word.half.lo;
                arb_req.mask = req_q.mask[3:0];
                arb_req.we   = req_q.we;
                arb_req.re   = req_q.re;
            end
            default: begin
                arb_req = '0;
            end
        endcase
    end

    // finish one cycle after the lower beat completes.
    assign rsp.finish = (state == ST_DONE);
    assign rsp.data   = rd_word.word;

endmodule

`default_nettype wire
